/* compile.f */
logic/seqPkg.sv
logic/microWordIf.sv
logic/controlStore.sv
logic/dispatchMux.sv
logic/callStack.sv
logic/diagReadback.sv
logic/microSequencer.sv
verification/microSequencerTb.sv

/* logic/callStack.sv */
// Ring-buffer subroutine return stack with wrapping pointer
`timescale 1ns/1ps
`default_nettype none

module callStack import seqPkg::*; #(
  parameter int stackDepthLog2 = 4
) (
  input  logic                      clk,
  input  logic                      RESET,
  microWordIf.seq                   uw,
  input  logic                      forceTrap,
  input  tCrAdr                     crAdr,
  output tCrAdr                     retAdr,
  output logic [stackDepthLog2-1:0] stackPtr
);

  localparam int stackDepth = 1 << stackDepthLog2;

  tCrAdr ring [0:stackDepth-1];
  logic [stackDepthLog2-1:0] topIdx;
  logic push;
  logic pop;

  // Trap wins over both call and return
  assign push = uw.call & ~forceTrap;
  assign pop  = (uw.disp == dispReturn) & ~forceTrap;

  ////////////////////
  // Ring and pointer

  always_ff @(posedge clk) begin
    if (RESET) begin
      stackPtr <= '0;
      for (int i = 0; i < stackDepth; i++) begin
        ring[i] <= '0;
      end
    end else if (push) begin
      ring[stackPtr] <= crAdr;
      stackPtr <= stackPtr + 1'b1;
    end else if (pop) begin
      stackPtr <= stackPtr - 1'b1;
    end
  end

  // Top of stack sits one below the pointer; wraps around the ring
  assign topIdx = stackPtr - 1'b1;
  assign retAdr = ring[topIdx];

endmodule

`default_nettype wire

/* logic/controlStore.sv */
// Writable 2K x 24 control store with load port and asynchronous read at crAdr
`timescale 1ns/1ps
`default_nettype none

module controlStore import seqPkg::*; (
  input  logic      clk,
  input  logic      RESET,
  input  logic      loadEn,
  input  tCrAdr     loadAdr,
  input  tMicroWord loadWord,
  input  tCrAdr     crAdr,
  microWordIf.store uw
);

  localparam int storeDepth = 2048;

  tMicroWord mem [0:storeDepth-1];
  tMicroWord curWord;

  ////////////////////
  // Load port

  // One word per cycle while loadEn is high
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAdr] <= loadWord;
    end
  end

  ////////////////////
  // Read and field split

  assign curWord = mem[crAdr];

  assign uw.jump = curWord.jump;
  assign uw.disp = curWord.disp;
  assign uw.cond = curWord.cond;
  assign uw.call = curWord.call;
  assign uw.uOp  = curWord.uOp;

  // Microcode is only written while the sequencer is parked in reset
  loadOnlyInReset: assert property (@(posedge clk) loadEn |-> RESET)
    else $error("control store written outside reset at %0t", $time);

endmodule

`default_nettype wire

/* logic/diagReadback.sv */
// Diagnostic read multiplexer, dispatch parity and micro-operation output
`timescale 1ns/1ps
`default_nettype none

module diagReadback import seqPkg::*; #(
  parameter int stackDepthLog2 = 4
) (
  microWordIf.view                  uw,
  input  tCrAdr                     crAdr,
  input  tCrAdr                     retAdr,
  input  logic [stackDepthLog2-1:0] stackPtr,
  input  logic [1:0]                diagSel,
  output tCrAdr                     diagData,
  output logic                      dispParity,
  output tUop                       uOp
);

  // Parity over call flag and dispatch field
  assign dispParity = ^{uw.call, uw.disp};

  // Datapath sees the operation field of the word at crAdr
  assign uOp = uw.uOp;

  always_comb begin
    case (diagSel)
      2'd0:    diagData = crAdr;
      2'd1:    diagData = retAdr;
      2'd2:    diagData = tCrAdr'(stackPtr);
      default: diagData = tCrAdr'({uw.disp, uw.cond});
    endcase
  end

endmodule

`default_nettype wire

/* logic/dispatchMux.sv */
// Next control RAM address: dispatch and skip select, trap forcing, diagnostic address latch
`timescale 1ns/1ps
`default_nettype none

module dispatchMux import seqPkg::*; (
  input  logic       clk,
  input  logic       RESET,
  microWordIf.seq    uw,
  input  logic [3:0] opcode,
  input  logic [3:0] flags,
  input  logic [7:0] condBits,
  input  logic       forceTrap,
  input  logic       diagLoad,
  input  tCrAdr      diagAdrIn,
  input  tCrAdr      retAdr,
  output tCrAdr      crAdr
);

  tCrAdr diagAdr;
  tCrAdr dispTerm;
  tCrAdr skipTerm;
  tCrAdr trapTerm;
  tCrAdr nextAdr;

  ////////////////////
  // Diagnostic address latch

  always_ff @(posedge clk) begin
    if (RESET) begin
      diagAdr <= '0;
    end else if (diagLoad) begin
      diagAdr <= diagAdrIn;
    end
  end

  ////////////////////
  // Dispatch term

  always_comb begin
    case (uw.disp)
      dispOpcode: dispTerm = {6'b0, opcode, 1'b0};
      dispFlags:  dispTerm = {7'b0, flags};
      dispDiag:   dispTerm = diagAdr;
      dispReturn: dispTerm = retAdr;
      default:    dispTerm = '0;
    endcase
  end

  // Skip only lands in bit 0 for a skip dispatch
  assign skipTerm = {10'b0, (uw.disp == dispSkip) & condBits[uw.cond]};

  assign trapTerm = forceTrap ? trapAdr : '0;

  // Everything is ORed, as in the original wired address bus
  assign nextAdr = uw.jump | dispTerm | skipTerm | trapTerm;

  ////////////////////
  // Address register

  always_ff @(posedge clk) begin
    if (RESET) begin
      crAdr <= '0;
    end else begin
      crAdr <= nextAdr;
    end
  end

  // Words fetched from the store never use the spare dispatch codes
  noSpareDisp: assert property (@(posedge clk) disable iff (RESET)
      uw.disp inside {dispNone, dispOpcode, dispFlags, dispDiag, dispReturn, dispSkip})
    else $error("spare dispatch code at crAdr %h", crAdr);

  // A word either calls or returns, the stack cannot do both
  noCallReturn: assert property (@(posedge clk) disable iff (RESET)
      !(uw.call && uw.disp == dispReturn))
    else $error("call and return in one word at crAdr %h", crAdr);

endmodule

`default_nettype wire

/* logic/microSequencer.sv */
// Microprogram sequencer top level: control store, next-address logic, stack and diagnostics
`timescale 1ns/1ps
`default_nettype none

module microSequencer import seqPkg::*; #(
  parameter int stackDepthLog2 = 4
) (
  input  logic       clk,
  input  logic       RESET,
  input  logic       loadEn,
  input  tCrAdr      loadAdr,
  input  tMicroWord  loadWord,
  input  logic [3:0] opcode,
  input  logic [3:0] flags,
  input  logic [7:0] condBits,
  input  logic       forceTrap,
  input  logic       diagLoad,
  input  tCrAdr      diagAdrIn,
  input  logic [1:0] diagSel,
  output tCrAdr      diagData,
  output tCrAdr      crAdr,
  output tUop        uOp,
  output logic       dispParity
);

  tCrAdr retAdr;
  logic [stackDepthLog2-1:0] stackPtr;

  microWordIf uw ();

  controlStore store (
    .clk      (clk),
    .RESET    (RESET),
    .loadEn   (loadEn),
    .loadAdr  (loadAdr),
    .loadWord (loadWord),
    .crAdr    (crAdr),
    .uw       (uw.store)
  );

  dispatchMux dispatch (
    .clk       (clk),
    .RESET     (RESET),
    .uw        (uw.seq),
    .opcode    (opcode),
    .flags     (flags),
    .condBits  (condBits),
    .forceTrap (forceTrap),
    .diagLoad  (diagLoad),
    .diagAdrIn (diagAdrIn),
    .retAdr    (retAdr),
    .crAdr     (crAdr)
  );

  callStack #(.stackDepthLog2(stackDepthLog2)) stack (
    .clk       (clk),
    .RESET     (RESET),
    .uw        (uw.seq),
    .forceTrap (forceTrap),
    .crAdr     (crAdr),
    .retAdr    (retAdr),
    .stackPtr  (stackPtr)
  );

  diagReadback #(.stackDepthLog2(stackDepthLog2)) diag (
    .uw         (uw.view),
    .crAdr      (crAdr),
    .retAdr     (retAdr),
    .stackPtr   (stackPtr),
    .diagSel    (diagSel),
    .diagData   (diagData),
    .dispParity (dispParity),
    .uOp        (uOp)
  );

endmodule

`default_nettype wire

/* logic/microWordIf.sv */
// Interface carrying the decoded fields of the current microword
`timescale 1ns/1ps
`default_nettype none

interface microWordIf import seqPkg::*; ();

  tCrAdr    jump;
  tDispSel  disp;
  tSkipCond cond;
  logic     call;
  tUop      uOp;

  // Control store side
  modport store (output jump, disp, cond, call, uOp);

  // Next-address and stack logic
  modport seq (input jump, disp, cond, call);

  // Diagnostic and datapath-facing side
  modport view (input disp, cond, call, uOp);

endinterface

`default_nettype wire

/* logic/seqPkg.sv */
// Shared sequencer types: address, microword layout, dispatch and condition codes, trap address
`default_nettype none

package seqPkg;

  // Control RAM address, 2K words
  typedef logic [10:0] tCrAdr;

  // Micro-operation field handed to the datapath
  typedef logic [5:0] tUop;

  // Dispatch source select, codes 6 and 7 are spare
  typedef enum logic [2:0] {
    dispNone   = 3'd0,
    dispOpcode = 3'd1,
    dispFlags  = 3'd2,
    dispDiag   = 3'd3,
    dispReturn = 3'd4,
    dispSkip   = 3'd5
  } tDispSel;

  // Skip conditions, value is the bit index into condBits
  typedef enum logic [2:0] {
    condCarry    = 3'd0,
    condZero     = 3'd1,
    condSign     = 3'd2,
    condOverflow = 3'd3,
    condParity   = 3'd4,
    condIntr     = 3'd5,
    condHalt     = 3'd6,
    condTrue     = 3'd7
  } tSkipCond;

  // 24-bit microword, jump field in the top bits
  typedef struct packed {
    tCrAdr    jump;
    tDispSel  disp;
    tSkipCond cond;
    logic     call;
    tUop      uOp;
  } tMicroWord;

  // Forced trap target, bits 9..1 set
  localparam tCrAdr trapAdr = 11'h3FE;

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build and run the microsequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module microSequencerTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VmicroSequencerTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1

/* verification/microSequencerTb.sv */
// Testbench for microSequencer: stimulus, reference address model, checks, watchdog, report
`timescale 1ns/1ps
`default_nettype none

module microSequencerTb import seqPkg::*; ();

  localparam int stackDepthLog2 = 4;
  localparam int ringSize = 1 << stackDepthLog2;
  localparam int clkPeriod = 4;
  localparam int resetCycles = 10;
  // Six reset phases, one closing cycle per test, then the run lengths
  localparam int totalCycles = 6 * (resetCycles + 1) + 6 + 8 + 30 + 60 + 90 + 80 + 30;

  logic clk, RESET, loadEn, forceTrap, diagLoad, dispParity;
  logic [3:0] opcode, flags;
  logic [7:0] condBits, condClr, condSet;
  logic [1:0] diagSel, selValue;
  logic selRandom, trapOn, diagOn;
  tCrAdr loadAdr, diagAdrIn, diagData, crAdr;
  tMicroWord loadWord;
  tUop uOp;
  integer seed = 32'hf873;
  int errCount, errAtStart, testsRun, testsFailed;
  tCrAdr loadAdrQ[$];
  tMicroWord loadWordQ[$];

  // Reference model state
  tMicroWord refMem [0:2047];
  tMicroWord curWord;
  tCrAdr expRing [0:ringSize-1];
  logic [stackDepthLog2-1:0] expPtr;
  tCrAdr expAdr, expDiagAdr, expRet, expNext, expDiag;
  logic expParity;

  microSequencer #(.stackDepthLog2(stackDepthLog2)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model

  always_comb begin
    tCrAdr term;
    curWord = refMem[expAdr];
    expRet = expRing[(int'(expPtr) + ringSize - 1) % ringSize];
    case (curWord.disp)
      dispOpcode: term = tCrAdr'(opcode) << 1;
      dispFlags:  term = tCrAdr'(flags);
      dispDiag:   term = expDiagAdr;
      dispReturn: term = expRet;
      dispSkip:   term = tCrAdr'(condBits[curWord.cond]);
      default:    term = '0;
    endcase
    expNext = curWord.jump | term | (forceTrap ? trapAdr : 11'h000);
    expParity = curWord.call ^ curWord.disp[2] ^ curWord.disp[1] ^ curWord.disp[0];
    case (diagSel)
      2'd0:    expDiag = expAdr;
      2'd1:    expDiag = expRet;
      2'd2:    expDiag = tCrAdr'(expPtr);
      default: expDiag = {5'b0, curWord.disp, curWord.cond};
    endcase
  end

  always @(posedge clk) begin
    if (loadEn) begin
      refMem[loadAdr] <= loadWord;
    end
    if (RESET) begin
      expAdr <= '0;
      expDiagAdr <= '0;
      expPtr <= '0;
      for (int i = 0; i < ringSize; i++) expRing[i] <= '0;
    end else begin
      expAdr <= expNext;
      if (diagLoad) begin
        expDiagAdr <= diagAdrIn;
      end
      // Trap blocks both stack moves
      if (!forceTrap && curWord.call) begin
        expRing[expPtr] <= expAdr;
        expPtr <= expPtr + 1'b1;
      end else if (!forceTrap && curWord.disp == dispReturn) begin
        expPtr <= expPtr - 1'b1;
      end
    end
  end

  ////////////////////
  // Checks against the model

  adrCheck: assert property (@(posedge clk) disable iff (RESET) crAdr == expAdr)
    else flagMismatch("crAdr", $sampled(crAdr), $sampled(expAdr));
  diagCheck: assert property (@(posedge clk) disable iff (RESET) diagData == expDiag)
    else flagMismatch("diagData", $sampled(diagData), $sampled(expDiag));
  parityCheck: assert property (@(posedge clk) disable iff (RESET) dispParity == expParity)
    else flagMismatch("dispParity", tCrAdr'($sampled(dispParity)), tCrAdr'($sampled(expParity)));
  uOpCheck: assert property (@(posedge clk) disable iff (RESET) uOp == curWord.uOp)
    else flagMismatch("uOp", tCrAdr'($sampled(uOp)), tCrAdr'($sampled(curWord.uOp)));

  task automatic flagMismatch(input string what, input tCrAdr got, input tCrAdr want);
    errCount++;
    $display("MISMATCH at %0t: %s is %h, model expects %h", $time, what, got, want);
  endtask

  ////////////////////
  // Stimulus tasks

  task automatic parkInputs();
    RESET = 1'b1;
    loadEn = 1'b0;
    loadAdr = '0;
    loadWord = '0;
    opcode = '0;
    flags = '0;
    condBits = '0;
    forceTrap = 1'b0;
    diagLoad = 1'b0;
    diagAdrIn = 11'h401;
    diagSel = 2'd2;
  endtask

  task automatic addWord(input tCrAdr adr, input tCrAdr jump, input tDispSel disp,
                         input tSkipCond cond, input logic call, input tUop op);
    loadAdrQ.push_back(adr);
    loadWordQ.push_back(tMicroWord'({jump, disp, cond, call, op}));
  endtask

  // Hold reset for ten cycles and write the queued words meanwhile
  task automatic resetAndLoad();
    for (int i = 0; i < resetCycles; i++) begin
      @(negedge clk);
      parkInputs();
      if (i < loadAdrQ.size()) begin
        loadEn = 1'b1;
        loadAdr = loadAdrQ[i];
        loadWord = loadWordQ[i];
      end
    end
    @(negedge clk);
    loadEn = 1'b0;
    RESET = 1'b0;
    loadAdrQ.delete();
    loadWordQ.delete();
  endtask

  task automatic runCycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      opcode = 4'($random(seed));
      flags = 4'($random(seed));
      condBits = (8'($random(seed)) & ~condClr) | condSet;
      diagSel = selRandom ? 2'($random(seed)) : selValue;
      forceTrap = trapOn & (2'($random(seed)) == 2'd0);
      diagLoad = diagOn & (3'($random(seed)) == 3'd0);
    end
  endtask

  task automatic finishTest(input string name);
    @(negedge clk);
    testsRun++;
    if (errCount != errAtStart) begin
      testsFailed++;
    end
    $display("Test %0d, %s: %0d mismatches", testsRun, name, errCount - errAtStart);
    errAtStart = errCount;
  endtask

  initial begin
    #((totalCycles + 50) * clkPeriod);
    $display("Timeout: tests did not finish within %0d cycles", totalCycles + 50);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////
  // Test sequence

  initial begin
    parkInputs();
    selRandom = 1'b0;
    selValue = 2'd2;
    trapOn = 1'b0;
    diagOn = 1'b0;
    condClr = '0;
    condSet = '0;

    // Plain jumps through scattered addresses
    addWord(11'h000, 11'h010, dispNone, condCarry, 1'b0, 6'h01);
    addWord(11'h010, 11'h123, dispNone, condZero, 1'b0, 6'h02);
    addWord(11'h123, 11'h7FF, dispNone, condSign, 1'b0, 6'h03);
    addWord(11'h7FF, 11'h555, dispNone, condCarry, 1'b0, 6'h04);
    addWord(11'h555, 11'h2AA, dispNone, condIntr, 1'b0, 6'h05);
    addWord(11'h2AA, 11'h000, dispNone, condCarry, 1'b0, 6'h06);
    resetAndLoad();
    runCycles(8);
    finishTest("reset state");
    selRandom = 1'b1;
    runCycles(30);
    finishTest("jump chain");

    // Skip into a flags dispatch, then an opcode dispatch, then back to 0
    addWord(11'h000, 11'h040, dispSkip, condSign, 1'b0, 6'h08);
    addWord(11'h040, 11'h08C, dispFlags, condCarry, 1'b0, 6'h09);
    addWord(11'h041, 11'h08C, dispFlags, condCarry, 1'b0, 6'h0A);
    for (int i = 0; i < 4; i++) begin
      addWord(11'h08C + tCrAdr'(i), 11'h0D8, dispOpcode, condCarry, 1'b0, 6'h0B);
    end
    resetAndLoad();
    for (int i = 0; i < 4; i++) begin
      addWord(11'h0D8 + tCrAdr'(2 * i), 11'h000, dispNone, condZero, 1'b0, 6'h0C);
    end
    resetAndLoad();
    runCycles(60);
    finishTest("skip and dispatch");

    // Recursive call word with a returning tail
    addWord(11'h000, 11'h100, dispNone, condCarry, 1'b1, 6'h10);
    addWord(11'h100, 11'h100, dispSkip, condHalt, 1'b1, 6'h11);
    addWord(11'h101, 11'h002, dispReturn, condCarry, 1'b0, 6'h12);
    addWord(11'h102, 11'h100, dispSkip, condHalt, 1'b0, 6'h13);
    addWord(11'h002, 11'h000, dispNone, condCarry, 1'b0, 6'h14);
    resetAndLoad();
    // Halt low nests calls past the ring depth, halt high unwinds them
    condClr = 8'h40;
    runCycles(30);
    condClr = 8'h00;
    condSet = 8'h40;
    runCycles(30);
    condSet = 8'h00;
    runCycles(30);
    finishTest("call and return");

    addWord(11'h000, 11'h000, dispDiag, condCarry, 1'b1, 6'h18);
    addWord(11'h401, 11'h000, dispReturn, condCarry, 1'b0, 6'h19);
    addWord(11'h3FE, 11'h401, dispNone, condCarry, 1'b0, 6'h1A);
    addWord(11'h7FF, 11'h000, dispNone, condCarry, 1'b0, 6'h1B);
    resetAndLoad();
    trapOn = 1'b1;
    diagOn = 1'b1;
    runCycles(80);
    trapOn = 1'b0;
    diagOn = 1'b0;
    finishTest("trap and diagnostic");

    addWord(11'h000, 11'h030, dispNone, condSign, 1'b1, 6'h20);
    addWord(11'h030, 11'h060, dispSkip, condParity, 1'b0, 6'h21);
    addWord(11'h060, 11'h000, dispReturn, condZero, 1'b0, 6'h22);
    addWord(11'h061, 11'h000, dispReturn, condOverflow, 1'b0, 6'h23);
    resetAndLoad();
    runCycles(30);
    finishTest("parity and readback");

    $display("Summary: %0d tests, %0d failed, %0d mismatches", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
